//--- design/ctl_settings.svh
`ifndef CTL_SETTINGS_SVH
`define CTL_SETTINGS_SVH

// ====================
// version words, low byte only.
`define CTL_VERSION_MAJOR 8'd12
`define CTL_VERSION_MINOR 8'd3

// ====================
// fixed register addresses.
`define CTL_ADDR_CTL_FLAG      8'h00
`define CTL_ADDR_FPGA_STATE    8'h01
`define CTL_ADDR_VERSION_MAJOR 8'h02
`define CTL_ADDR_VERSION_MINOR 8'h03

// block base addresses.
`define CTL_ADDR_SILENCER_BASE 8'h40
`define CTL_ADDR_PWE_BASE      8'h50
`define CTL_ADDR_SYNC_BASE     8'h60

// block lengths in words.
`define CTL_SILENCER_WORDS 3'd5
`define CTL_PWE_WORDS      3'd1
`define CTL_SYNC_WORDS     3'd6

// ====================
// control flag word.
`define CTL_FLAG_BIT_SILENCER_SET 0
`define CTL_FLAG_BIT_PWE_SET      1
`define CTL_FLAG_BIT_SYNC_SET     2
`define CTL_FLAG_BIT_FORCE_FAN    4
`define CTL_FLAG_BIT_GPIO_IN_BASE 8 // four bits from here.

// bank read latency in cycles.
`define CTL_RD_LATENCY 2

`endif

//--- design/ctl_pkg.sv
`default_nettype none

package ctl_pkg;

    // ====================
    // bank types.
    typedef logic [15:0] ctl_word_t;
    typedef logic [7:0] ctl_addr_t;

    // block selector, also the bit index of word_valid and load_done.
    typedef enum logic [1:0] {
        BLK_SILENCER = 2'd0,
        BLK_PWE      = 2'd1,
        BLK_SYNC     = 2'd2
    } ctl_block_t;

    // ====================
    // settings blocks.
    // first word read sits in the low 16 bits, so fields go msb first here.
    typedef struct packed {
        ctl_word_t completion_steps_phase;     // word 4.
        ctl_word_t completion_steps_intensity; // word 3.
        ctl_word_t update_rate_phase;          // word 2.
        ctl_word_t update_rate_intensity;      // word 1.
        ctl_word_t mode;                       // word 0, only bit 0 used.
    } silencer_settings_t;

    typedef struct packed {
        ctl_word_t full_width_start;
    } pwe_settings_t;

    typedef struct packed {
        logic [31:0] base_cnt;  // words 4 and 5.
        logic [63:0] sync_time; // words 0 to 3, low half first.
    } sync_settings_t;

endpackage

`default_nettype wire

//--- design/cnt_ram.sv
`timescale 1ns/1ps
`default_nettype none

module cnt_ram (
    input  wire                     CLK,
    // host side.
    input  wire                     host_we,
    input  wire ctl_pkg::ctl_addr_t host_addr,
    input  wire ctl_pkg::ctl_word_t host_wdata,
    output ctl_pkg::ctl_word_t      host_rdata,
    // controller side.
    input  wire                     ctl_we,
    input  wire ctl_pkg::ctl_addr_t ctl_addr,
    input  wire ctl_pkg::ctl_word_t ctl_wdata,
    output ctl_pkg::ctl_word_t      ctl_rdata
);
    import ctl_pkg::*;

    ctl_word_t mem [0:255];

    ctl_addr_t host_addr_q;
    ctl_addr_t ctl_addr_q;

    // ====================
    // write side.
    // controller port comes last so it wins on a same-address collision.
    always_ff @(posedge CLK) begin
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        if (ctl_we) begin
            mem[ctl_addr] <= ctl_wdata;
        end
    end

    // ====================
    // read side, address stage then data stage.
    always_ff @(posedge CLK) begin
        host_addr_q <= host_addr;
        host_rdata <= mem[host_addr_q];
    end

    always_ff @(posedge CLK) begin
        ctl_addr_q <= ctl_addr;
        ctl_rdata <= mem[ctl_addr_q]; // two edges after the address.
    end

endmodule

`default_nettype wire

//--- design/ctl_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module ctl_scheduler (
    input  wire                     CLK,
    input  wire                     rst_n,
    input  wire                     thermo,
    input  wire ctl_pkg::ctl_word_t ctl_rdata,
    output logic                    ctl_we,
    output ctl_pkg::ctl_addr_t      ctl_addr,
    output ctl_pkg::ctl_word_t      ctl_wdata,
    output logic                    force_fan,
    output logic [3:0]              gpio_in,
    output logic [2:0]              word_valid,
    output logic [2:0]              word_index,
    output ctl_pkg::ctl_word_t      word_data,
    output logic [2:0]              load_done
);
    import ctl_pkg::*;

    typedef enum logic [3:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_STATUS,
        ST_POLL_RD,
        ST_POLL_W0,
        ST_POLL_W1,
        ST_LATCH,
        ST_BURST,
        ST_DRAIN,
        ST_WB
    } state_t;

    state_t     state;
    ctl_word_t  flags;     // local copy of the flag word.
    ctl_block_t blk;
    logic [2:0] issue_cnt;
    logic [2:0] ret_cnt;
    logic [`CTL_RD_LATENCY:0] rd_pipe;

    logic       issue;
    logic       ret_valid;
    ctl_addr_t  blk_base;
    logic [2:0] blk_len;
    logic       req_any;
    ctl_block_t next_blk;
    ctl_word_t  clr_mask;

    // ====================
    // block lookup.
    always_comb begin
        case (blk)
            BLK_SILENCER: begin
                blk_base = `CTL_ADDR_SILENCER_BASE;
                blk_len = `CTL_SILENCER_WORDS;
            end
            BLK_PWE: begin
                blk_base = `CTL_ADDR_PWE_BASE;
                blk_len = `CTL_PWE_WORDS;
            end
            BLK_SYNC: begin
                blk_base = `CTL_ADDR_SYNC_BASE;
                blk_len = `CTL_SYNC_WORDS;
            end
            default: begin
                blk_base = `CTL_ADDR_SYNC_BASE;
                blk_len = `CTL_SYNC_WORDS;
            end
        endcase
    end

    // request priority on the flag word as it returns.
    always_comb begin
        req_any = 1'b1;
        next_blk = BLK_SILENCER;
        clr_mask = '0;
        if (ctl_rdata[`CTL_FLAG_BIT_SILENCER_SET]) begin
            clr_mask[`CTL_FLAG_BIT_SILENCER_SET] = 1'b1;
        end else if (ctl_rdata[`CTL_FLAG_BIT_PWE_SET]) begin
            next_blk = BLK_PWE;
            clr_mask[`CTL_FLAG_BIT_PWE_SET] = 1'b1;
        end else if (ctl_rdata[`CTL_FLAG_BIT_SYNC_SET]) begin
            next_blk = BLK_SYNC;
            clr_mask[`CTL_FLAG_BIT_SYNC_SET] = 1'b1;
        end else begin
            req_any = 1'b0;
        end
    end

    assign issue = (state == ST_BURST);
    assign ret_valid = rd_pipe[`CTL_RD_LATENCY];

    // ====================
    // control FSM.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= ST_VER_MINOR;
            flags <= '0;
            blk <= BLK_SILENCER;
            issue_cnt <= '0;
            ret_cnt <= '0;
            rd_pipe <= '0;
            ctl_we <= 1'b0;
            load_done <= '0;
        end else begin
            ctl_we <= 1'b0;
            load_done <= '0;
            rd_pipe <= {rd_pipe[`CTL_RD_LATENCY-1:0], issue};
            if (ret_valid) begin
                ret_cnt <= ret_cnt + 3'd1;
            end

            case (state)
                ST_VER_MINOR: begin
                    ctl_we <= 1'b1;
                    state <= ST_VER_MAJOR;
                end
                ST_VER_MAJOR: begin
                    ctl_we <= 1'b1;
                    state <= ST_STATUS;
                end
                ST_STATUS: begin
                    ctl_we <= 1'b1;
                    state <= ST_POLL_RD;
                end
                ST_POLL_RD: state <= ST_POLL_W0;
                ST_POLL_W0: state <= ST_POLL_W1;
                ST_POLL_W1: state <= ST_LATCH;
                ST_LATCH: begin
                    flags <= ctl_rdata & ~clr_mask;
                    if (req_any) begin
                        blk <= next_blk;
                        issue_cnt <= '0;
                        ret_cnt <= '0;
                        state <= ST_BURST;
                    end else begin
                        state <= ST_STATUS;
                    end
                end
                ST_BURST: begin
                    issue_cnt <= issue_cnt + 3'd1;
                    if (issue_cnt == blk_len - 3'd1) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (ret_valid && ret_cnt == blk_len - 3'd1) begin
                        state <= ST_WB;
                    end
                end
                ST_WB: begin
                    ctl_we <= 1'b1; // flag write-back.
                    load_done <= 3'b001 << blk;
                    state <= ST_STATUS;
                end
                default: state <= ST_STATUS;
            endcase
        end
    end

    // bus address and data.
    always_ff @(posedge CLK) begin
        case (state)
            ST_VER_MINOR: begin
                ctl_addr <= `CTL_ADDR_VERSION_MINOR;
                ctl_wdata <= {8'h00, `CTL_VERSION_MINOR};
            end
            ST_VER_MAJOR: begin
                ctl_addr <= `CTL_ADDR_VERSION_MAJOR;
                ctl_wdata <= {8'h00, `CTL_VERSION_MAJOR};
            end
            ST_STATUS: begin
                ctl_addr <= `CTL_ADDR_FPGA_STATE;
                ctl_wdata <= {15'd0, thermo};
            end
            ST_POLL_RD: ctl_addr <= `CTL_ADDR_CTL_FLAG;
            ST_BURST: ctl_addr <= blk_base + ctl_addr_t'(issue_cnt);
            ST_WB: begin
                ctl_addr <= `CTL_ADDR_CTL_FLAG;
                ctl_wdata <= flags;
            end
            default: ;
        endcase
    end

    // ====================
    // capture strobes and level outputs.
    assign word_valid = ret_valid ? (3'b001 << blk) : 3'b000;
    assign word_index = ret_cnt;
    assign word_data = ctl_rdata;

    assign force_fan = flags[`CTL_FLAG_BIT_FORCE_FAN];
    assign gpio_in = flags[`CTL_FLAG_BIT_GPIO_IN_BASE +: 4];

    // word strobes and commit strobes never share a cycle.
    a_strobe_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
        $onehot0({word_valid, load_done}))
        else $error("more than one strobe bit high");

endmodule

`default_nettype wire

//--- design/settings_capture.sv
`timescale 1ns/1ps
`default_nettype none

module settings_capture #(
    parameter type payload_t = logic [15:0],
    parameter payload_t RESET_VALUE = '0
) (
    input  wire                     CLK,
    input  wire                     rst_n,
    input  wire                     word_valid,
    input  wire [2:0]               word_index,
    input  wire ctl_pkg::ctl_word_t word_data,
    input  wire                     load_done,
    output payload_t                settings,
    output logic                    update
);
    import ctl_pkg::*;

    localparam int NUM_WORDS = $bits(payload_t) / $bits(ctl_word_t);

    ctl_word_t [NUM_WORDS-1:0] staging;

    // ====================
    // staging fills word by word, word 0 lowest.
    always_ff @(posedge CLK) begin
        if (word_valid) begin
            staging[word_index] <= word_data;
        end
    end

    // new settings go out together with the pulse.
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            settings <= RESET_VALUE;
            update <= 1'b0;
        end else begin
            update <= load_done; // one cycle only.
            if (load_done) begin
                settings <= payload_t'(staging);
            end
        end
    end

    // ====================
    // burst length must agree with the payload this instance holds.
    a_index_range: assert property (@(posedge CLK) disable iff (!rst_n)
        word_valid |-> (word_index < NUM_WORDS))
        else $error("word index %0d beyond block of %0d words", word_index, NUM_WORDS);

    // the scheduler finishes the burst before it commits.
    a_done_after_words: assert property (@(posedge CLK) disable iff (!rst_n)
        !(word_valid && load_done))
        else $error("load_done during word transfer");

endmodule

`default_nettype wire

//--- design/ctl_controller.sv
`timescale 1ns/1ps
`default_nettype none

module ctl_controller (
    input  wire                         CLK,
    input  wire                         rst_n,
    input  wire                         thermo,
    input  wire                         host_we,
    input  wire ctl_pkg::ctl_addr_t     host_addr,
    input  wire ctl_pkg::ctl_word_t     host_wdata,
    output ctl_pkg::ctl_word_t          host_rdata,
    output logic                        force_fan,
    output logic [3:0]                  gpio_in,
    output ctl_pkg::silencer_settings_t silencer_settings,
    output logic                        silencer_update,
    output ctl_pkg::pwe_settings_t      pwe_settings,
    output logic                        pwe_update,
    output ctl_pkg::sync_settings_t     sync_settings,
    output logic                        sync_update
);
    import ctl_pkg::*;

    // ====================
    // power-up settings.
    localparam silencer_settings_t SILENCER_RESET = '{
        completion_steps_phase: 16'd40,
        completion_steps_intensity: 16'd10,
        update_rate_phase: 16'd256,
        update_rate_intensity: 16'd256,
        mode: 16'd0
    };
    localparam pwe_settings_t PWE_RESET = '{full_width_start: 16'd65025};
    localparam sync_settings_t SYNC_RESET = '{base_cnt: 32'd10240, sync_time: 64'd0};

    logic       ctl_we;
    ctl_addr_t  ctl_addr;
    ctl_word_t  ctl_wdata;
    ctl_word_t  ctl_rdata;
    logic [2:0] word_valid;
    logic [2:0] word_index;
    ctl_word_t  word_data;
    logic [2:0] load_done;

    cnt_ram cnt_ram_i (
        .CLK(CLK),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata),
        .ctl_we(ctl_we), .ctl_addr(ctl_addr), .ctl_wdata(ctl_wdata), .ctl_rdata(ctl_rdata)
    );

    ctl_scheduler ctl_scheduler_i (
        .CLK(CLK), .rst_n(rst_n), .thermo(thermo), .ctl_rdata(ctl_rdata),
        .ctl_we(ctl_we), .ctl_addr(ctl_addr), .ctl_wdata(ctl_wdata),
        .force_fan(force_fan), .gpio_in(gpio_in),
        .word_valid(word_valid), .word_index(word_index), .word_data(word_data),
        .load_done(load_done)
    );

    // ====================
    // one capture per block.
    settings_capture #(.payload_t(silencer_settings_t), .RESET_VALUE(SILENCER_RESET))
    silencer_capture_i (
        .CLK(CLK), .rst_n(rst_n), .word_valid(word_valid[BLK_SILENCER]),
        .word_index(word_index), .word_data(word_data), .load_done(load_done[BLK_SILENCER]),
        .settings(silencer_settings), .update(silencer_update)
    );

    settings_capture #(.payload_t(pwe_settings_t), .RESET_VALUE(PWE_RESET)) pwe_capture_i (
        .CLK(CLK), .rst_n(rst_n), .word_valid(word_valid[BLK_PWE]),
        .word_index(word_index), .word_data(word_data), .load_done(load_done[BLK_PWE]),
        .settings(pwe_settings), .update(pwe_update)
    );

    settings_capture #(.payload_t(sync_settings_t), .RESET_VALUE(SYNC_RESET)) sync_capture_i (
        .CLK(CLK), .rst_n(rst_n), .word_valid(word_valid[BLK_SYNC]),
        .word_index(word_index), .word_data(word_data), .load_done(load_done[BLK_SYNC]),
        .settings(sync_settings), .update(sync_update)
    );

endmodule

`default_nettype wire

//--- verif/tb_ctl_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctl_settings.svh"

module tb_ctl_controller;
    import ctl_pkg::*;

    localparam int SEED = 18112;
    localparam int WATCHDOG_NS = 200_000; // whole run is a few thousand cycles.
    localparam int UPDATE_TIMEOUT = 100;  // cycles, covers the longest queued load.
    localparam int SIL_LEN = int'(`CTL_SILENCER_WORDS);
    localparam int SYNC_LEN = int'(`CTL_SYNC_WORDS);

    logic               CLK;
    logic               rst_n;
    logic               thermo;
    logic               host_we;
    ctl_addr_t          host_addr;
    ctl_word_t          host_wdata;
    ctl_word_t          host_rdata;
    logic               force_fan;
    logic [3:0]         gpio_in;
    silencer_settings_t silencer_settings;
    logic               silencer_update;
    pwe_settings_t      pwe_settings;
    logic               pwe_update;
    sync_settings_t     sync_settings;
    logic               sync_update;

    // expected block contents, word 0 first.
    ctl_word_t  sil_words [SIL_LEN];
    ctl_word_t  pwe_word;
    ctl_word_t  sync_words [SYNC_LEN];
    ctl_block_t pulse_order [$];
    int         error_count = 0;
    int         fail_count = 0;

    ctl_controller ctl_controller_i (
        .CLK(CLK), .rst_n(rst_n), .thermo(thermo),
        .host_we(host_we), .host_addr(host_addr), .host_wdata(host_wdata),
        .host_rdata(host_rdata), .force_fan(force_fan), .gpio_in(gpio_in),
        .silencer_settings(silencer_settings), .silencer_update(silencer_update),
        .pwe_settings(pwe_settings), .pwe_update(pwe_update),
        .sync_settings(sync_settings), .sync_update(sync_update)
    );

    // ====================
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // update pulses in arrival order.
    always @(negedge CLK) begin
        if (rst_n) begin
            if (silencer_update) pulse_order.push_back(BLK_SILENCER);
            if (pwe_update) pulse_order.push_back(BLK_PWE);
            if (sync_update) pulse_order.push_back(BLK_SYNC);
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    // ====================
    task automatic step();
        @(posedge CLK);
        #1;
    endtask

    task automatic host_write(input ctl_addr_t addr, input ctl_word_t data);
        host_we = 1'b1;
        host_addr = addr;
        host_wdata = data;
        step();
        host_we = 1'b0;
    endtask

    task automatic host_read(input ctl_addr_t addr, output ctl_word_t data);
        host_addr = addr;
        step();
        step(); // two-cycle read.
        data = host_rdata;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expected, actual);
    endtask

    function automatic logic update_of(input ctl_block_t blk);
        case (blk)
            BLK_SILENCER: return silencer_update;
            BLK_PWE: return pwe_update;
            default: return sync_update;
        endcase
    endfunction

    task automatic wait_for_update(input ctl_block_t blk, input string name);
        int cycles;
        cycles = 0;
        while (!update_of(blk) && cycles < UPDATE_TIMEOUT) begin
            step();
            cycles++;
        end
        if (!update_of(blk)) begin
            fail_count++;
            $display("no %s update pulse within %0d cycles", name, UPDATE_TIMEOUT);
        end
    endtask

    task automatic fill_blocks();
        for (int i = 0; i < SIL_LEN; i++) begin
            sil_words[i] = 16'($urandom);
            host_write(`CTL_ADDR_SILENCER_BASE + 8'(i), sil_words[i]);
        end
        pwe_word = 16'($urandom);
        host_write(`CTL_ADDR_PWE_BASE, pwe_word);
        for (int i = 0; i < SYNC_LEN; i++) begin
            sync_words[i] = 16'($urandom);
            host_write(`CTL_ADDR_SYNC_BASE + 8'(i), sync_words[i]);
        end
    endtask

    // ====================
    task automatic check_silencer();
        silencer_settings_t s;
        s = silencer_settings;
        if (s.mode !== sil_words[0])
            report_mismatch("silencer_settings.mode", 64'(sil_words[0]), 64'(s.mode));
        if (s.update_rate_intensity !== sil_words[1])
            report_mismatch("silencer_settings.update_rate_intensity",
                64'(sil_words[1]), 64'(s.update_rate_intensity));
        if (s.update_rate_phase !== sil_words[2])
            report_mismatch("silencer_settings.update_rate_phase",
                64'(sil_words[2]), 64'(s.update_rate_phase));
        if (s.completion_steps_intensity !== sil_words[3])
            report_mismatch("silencer_settings.completion_steps_intensity",
                64'(sil_words[3]), 64'(s.completion_steps_intensity));
        if (s.completion_steps_phase !== sil_words[4])
            report_mismatch("silencer_settings.completion_steps_phase",
                64'(sil_words[4]), 64'(s.completion_steps_phase));
    endtask

    task automatic check_pwe();
        if (pwe_settings.full_width_start !== pwe_word)
            report_mismatch("pwe_settings.full_width_start",
                64'(pwe_word), 64'(pwe_settings.full_width_start));
    endtask

    task automatic check_sync();
        logic [63:0] exp_time;
        logic [31:0] exp_base;
        exp_time = {sync_words[3], sync_words[2], sync_words[1], sync_words[0]};
        exp_base = {sync_words[5], sync_words[4]};
        if (sync_settings.sync_time !== exp_time)
            report_mismatch("sync_settings.sync_time", exp_time, sync_settings.sync_time);
        if (sync_settings.base_cnt !== exp_base)
            report_mismatch("sync_settings.base_cnt", 64'(exp_base), 64'(sync_settings.base_cnt));
    endtask

    task automatic check_flag_cleared(input ctl_word_t mask);
        ctl_word_t rd;
        host_read(`CTL_ADDR_CTL_FLAG, rd);
        if ((rd & mask) !== 16'h0000)
            report_mismatch("host_rdata (flag word set bits)", 64'd0, 64'(rd & mask));
    endtask

    // ====================
    task automatic test_reset_and_version();
        ctl_word_t rd;
        host_write(`CTL_ADDR_CTL_FLAG, 16'h0000); // bank content is unknown at power-up.
        repeat (4) step();
        sil_words = '{16'd0, 16'd256, 16'd256, 16'd10, 16'd40};
        pwe_word = 16'd65025;
        sync_words = '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h2800, 16'h0000};
        check_silencer();
        check_pwe();
        check_sync();
        if (pulse_order.size() != 0) begin
            fail_count++;
            $display("an update pulse fired straight after reset");
        end
        host_read(`CTL_ADDR_VERSION_MAJOR, rd);
        if (rd[7:0] !== `CTL_VERSION_MAJOR)
            report_mismatch("host_rdata (version major)", 64'(`CTL_VERSION_MAJOR), 64'(rd[7:0]));
        host_read(`CTL_ADDR_VERSION_MINOR, rd);
        if (rd[7:0] !== `CTL_VERSION_MINOR)
            report_mismatch("host_rdata (version minor)", 64'(`CTL_VERSION_MINOR), 64'(rd[7:0]));
    endtask

    task automatic test_status_word();
        ctl_word_t rd;
        thermo = 1'b1;
        repeat (20) step();
        host_read(`CTL_ADDR_FPGA_STATE, rd);
        if (rd !== 16'h0001) report_mismatch("host_rdata (status, thermo high)", 64'd1, 64'(rd));
        thermo = 1'b0;
        repeat (20) step();
        host_read(`CTL_ADDR_FPGA_STATE, rd);
        if (rd !== 16'h0000) report_mismatch("host_rdata (status, thermo low)", 64'd0, 64'(rd));
    endtask

    task automatic test_single_load(input ctl_block_t blk, input int flag_bit,
                                    input string name);
        fill_blocks();
        host_write(`CTL_ADDR_CTL_FLAG, 16'h0001 << flag_bit);
        wait_for_update(blk, name);
        if (blk == BLK_SILENCER) check_silencer();
        else check_sync();
        check_flag_cleared(16'h0001 << flag_bit);
    endtask

    task automatic test_priority();
        fill_blocks();
        pulse_order.delete();
        host_write(`CTL_ADDR_CTL_FLAG, (16'h0001 << `CTL_FLAG_BIT_SILENCER_SET)
            | (16'h0001 << `CTL_FLAG_BIT_PWE_SET) | (16'h0001 << `CTL_FLAG_BIT_SYNC_SET));
        wait_for_update(BLK_SILENCER, "silencer");
        check_silencer();
        wait_for_update(BLK_PWE, "pulse-width encoder");
        check_pwe();
        wait_for_update(BLK_SYNC, "sync");
        check_sync();
        step();
        if (pulse_order.size() != 3 || pulse_order[0] != BLK_SILENCER
            || pulse_order[1] != BLK_PWE || pulse_order[2] != BLK_SYNC) begin
            fail_count++;
            $display("update pulses not in silencer, pulse-width encoder, sync order");
        end
        check_flag_cleared(16'h0007);
    endtask

    task automatic test_level_outputs();
        logic [3:0] gpio;
        int         pulses_before;
        gpio = 4'($urandom);
        pulses_before = pulse_order.size();
        host_write(`CTL_ADDR_CTL_FLAG, (16'h0001 << `CTL_FLAG_BIT_FORCE_FAN)
            | (16'(gpio) << `CTL_FLAG_BIT_GPIO_IN_BASE));
        repeat (20) step();
        if (force_fan !== 1'b1) report_mismatch("force_fan", 64'd1, 64'(force_fan));
        if (gpio_in !== gpio) report_mismatch("gpio_in", 64'(gpio), 64'(gpio_in));
        if (pulse_order.size() != pulses_before) begin
            fail_count++;
            $display("update pulse fired with no set bit in the flag word");
        end
    endtask

    // ====================
    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        thermo = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        repeat (2) @(posedge CLK);
        #1;
        rst_n = 1'b1;

        test_reset_and_version();
        test_status_word();
        test_single_load(BLK_SILENCER, `CTL_FLAG_BIT_SILENCER_SET, "silencer");
        test_single_load(BLK_SYNC, `CTL_FLAG_BIT_SYNC_SET, "sync");
        test_priority();
        test_level_outputs();

        $display("summary: %0d value mismatches, %0d other failures", error_count, fail_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+design
design/ctl_pkg.sv
design/cnt_ram.sv
design/ctl_scheduler.sv
design/settings_capture.sv
design/ctl_controller.sv
verif/tb_ctl_controller.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
TOP        ?= tb_ctl_controller
RTL_TOP    ?= ctl_controller
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
